// ==== hdl/cache_pkg.sv ====
// cache line store definitions
`default_nettype none

package cache_pkg;

    localparam int ABUS     = 32;                    // system address width
    localparam int IBITS    = 4;                     // set index width
    localparam int LNBITS   = 4;                     // log2 of bytes per line
    localparam int FLBITS   = 4;                     // flags kept with each tag, bit 0 is valid
    localparam int TAG_BITS = ABUS - IBITS - LNBITS;

    localparam int SETS       = 2 ** IBITS;
    localparam int LINE_BYTES = 2 ** LNBITS;
    localparam int LINE_BITS  = 8 * LINE_BYTES;

    typedef logic [ABUS-1:0]       addr_t;
    typedef logic [IBITS-1:0]      index_t;
    typedef logic [TAG_BITS-1:0]   tag_t;
    typedef logic [FLBITS-1:0]     flags_t;
    typedef logic [LINE_BYTES-1:0] wstrb_t;
    typedef logic [LINE_BITS-1:0]  line_t;
    typedef logic                  way_t;

    // access request, a write when wstrb is nonzero
    typedef struct packed {
        addr_t  addr;
        wstrb_t wstrb;
        line_t  wdata;
        flags_t wflags;
    } line_req_t;

    // lookup result, one cycle after the request
    typedef struct packed {
        addr_t  raddr;   // line address, byte offset cleared
        line_t  rdata;
        flags_t rflags;
        logic   hit;
    } line_rsp_t;

endpackage

`default_nettype wire

// ==== hdl/ram_tech.sv ====
// tag word RAM
`default_nettype none

module ram_tech #(
    parameter int DBITS = 28
) (
    input  logic                  i_clk,
    input  cache_pkg::index_t     i_addr,
    input  logic                  i_wena,
    input  logic [DBITS-1:0]      i_wdata,
    output logic [DBITS-1:0]      o_rdata
);

    logic [DBITS-1:0] mem [cache_pkg::SETS];

    // read-first: the registered output sees the word before the write lands
    always_ff @(posedge i_clk) begin
        if (i_wena) begin
            mem[i_addr] <= i_wdata;
        end
        o_rdata <= mem[i_addr];
    end

endmodule

`default_nettype wire

// ==== hdl/ram_cache_bwe_tech.sv ====
// line data RAM with byte enables
`default_nettype none

module ram_cache_bwe_tech (
    input  logic                i_clk,
    input  cache_pkg::index_t   i_addr,
    input  cache_pkg::wstrb_t   i_wena,     // one enable per byte
    input  cache_pkg::line_t    i_wdata,
    output cache_pkg::line_t    o_rdata
);

    cache_pkg::line_t mem [cache_pkg::SETS];

    always_ff @(posedge i_clk) begin
        for (int i = 0; i < cache_pkg::LINE_BYTES; i++) begin
            if (i_wena[i]) begin
                mem[i_addr][8*i +: 8] <= i_wdata[8*i +: 8];
            end
        end
        o_rdata <= mem[i_addr];     // old line on a same-cycle write
    end

endmodule

`default_nettype wire

// ==== hdl/tag_mem.sv ====
// cache way tag and data store
`default_nettype none

module tag_mem (
    input  logic                  i_clk,
    input  logic                  i_nrst,
    input  cache_pkg::line_req_t  i_req,
    input  cache_pkg::addr_t      i_snoop_addr,
    output cache_pkg::line_rsp_t  o_rsp,
    output cache_pkg::flags_t     o_snoop_flags
);

    // stored word is {flags, tag}
    localparam int TWBITS = cache_pkg::TAG_BITS + cache_pkg::FLBITS;

    typedef logic [TWBITS-1:0] tag_word_t;

    cache_pkg::index_t req_index;
    cache_pkg::index_t snoop_index;
    cache_pkg::index_t r_index;
    cache_pkg::tag_t   req_tag;
    cache_pkg::tag_t   snoop_tag;
    cache_pkg::tag_t   r_tag;
    cache_pkg::tag_t   r_snoop_tag;
    logic              tag_we;
    tag_word_t         tag_wdata;
    tag_word_t         tag_rdata;
    tag_word_t         snoop_rdata;
    cache_pkg::line_t  line_rdata;

    assign req_index = i_req.addr[cache_pkg::LNBITS +: cache_pkg::IBITS];
    assign req_tag   = i_req.addr[cache_pkg::ABUS-1 -: cache_pkg::TAG_BITS];
    assign snoop_tag = i_snoop_addr[cache_pkg::ABUS-1 -: cache_pkg::TAG_BITS];

    assign tag_we    = |i_req.wstrb;                 // any strobe rewrites tag and flags
    assign tag_wdata = {i_req.wflags, req_tag};

    // snoop copy shares the write, so its index follows the write address
    assign snoop_index = tag_we ? req_index
                                : i_snoop_addr[cache_pkg::LNBITS +: cache_pkg::IBITS];

    ram_cache_bwe_tech data0 (
        .i_clk   (i_clk),
        .i_addr  (req_index),
        .i_wena  (i_req.wstrb),
        .i_wdata (i_req.wdata),
        .o_rdata (line_rdata)
    );

    ram_tech #(
        .DBITS (TWBITS)
    ) tag0 (
        .i_clk   (i_clk),
        .i_addr  (req_index),
        .i_wena  (tag_we),
        .i_wdata (tag_wdata),
        .o_rdata (tag_rdata)
    );

    ram_tech #(
        .DBITS (TWBITS)
    ) tagsnoop0 (
        .i_clk   (i_clk),
        .i_addr  (snoop_index),
        .i_wena  (tag_we),
        .i_wdata (tag_wdata),
        .o_rdata (snoop_rdata)
    );

    // lookup state for the compare in the next cycle
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            r_tag       <= '0;
            r_index     <= '0;
            r_snoop_tag <= '0;
        end else begin
            r_tag       <= req_tag;
            r_index     <= req_index;
            r_snoop_tag <= snoop_tag;
        end
    end

    always_comb begin
        o_rsp.raddr  = {tag_rdata[cache_pkg::TAG_BITS-1:0], r_index,
                        {cache_pkg::LNBITS{1'b0}}};
        o_rsp.rdata  = line_rdata;
        o_rsp.rflags = tag_rdata[TWBITS-1:cache_pkg::TAG_BITS];
        // valid flag only counts when the tag matches
        o_rsp.hit    = (tag_rdata[cache_pkg::TAG_BITS-1:0] == r_tag)
                       & tag_rdata[cache_pkg::TAG_BITS];
    end

    always_comb begin
        o_snoop_flags = '0;
        if (snoop_rdata[cache_pkg::TAG_BITS-1:0] == r_snoop_tag) begin
            o_snoop_flags = snoop_rdata[TWBITS-1:cache_pkg::TAG_BITS];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/lru_table.sv ====
// per set LRU victim table
`default_nettype none

module lru_table (
    input  logic                i_clk,
    input  logic                i_nrst,
    input  cache_pkg::index_t   i_index,     // index of the current access
    input  logic                i_we,
    input  cache_pkg::way_t     i_wway,
    input  logic                i_hit,       // result of last cycle's access
    input  cache_pkg::way_t     i_hit_way,
    output cache_pkg::way_t     o_victim
);

    logic [cache_pkg::SETS-1:0] victim;    // one bit per set, the way to replace next
    cache_pkg::index_t          r_index;

    assign o_victim = victim[i_index];

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            victim  <= '0;
            r_index <= '0;
        end else begin
            r_index <= i_index;
            if (i_hit) begin
                victim[r_index] <= ~i_hit_way;
            end
            // later assignment wins on the same set
            if (i_we) begin
                victim[i_index] <= ~i_wway;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/cache_lines.sv ====
// two way cache line store
`default_nettype none

module cache_lines (
    input  logic                  i_clk,
    input  logic                  i_nrst,
    input  cache_pkg::line_req_t  i_req,
    input  logic                  i_refill,      // write allocates the LRU victim
    input  cache_pkg::way_t       i_wway,        // target way for non-refill writes
    input  cache_pkg::addr_t      i_snoop_addr,
    output cache_pkg::line_rsp_t  o_rsp,
    output cache_pkg::way_t       o_hit_way,
    output cache_pkg::flags_t     o_snoop_flags
);

    cache_pkg::line_req_t req0;
    cache_pkg::line_req_t req1;
    cache_pkg::line_rsp_t rsp0;
    cache_pkg::line_rsp_t rsp1;
    cache_pkg::flags_t    snoop0;
    cache_pkg::flags_t    snoop1;
    cache_pkg::way_t      victim;
    cache_pkg::way_t      wr_way;

    assign wr_way = i_refill ? victim : i_wway;

    // only the selected way sees the strobes
    always_comb begin
        req0 = i_req;
        req1 = i_req;
        req0.wstrb = (wr_way == 1'b0) ? i_req.wstrb : '0;
        req1.wstrb = (wr_way == 1'b1) ? i_req.wstrb : '0;
    end

    tag_mem way0 (
        .i_clk         (i_clk),
        .i_nrst        (i_nrst),
        .i_req         (req0),
        .i_snoop_addr  (i_snoop_addr),
        .o_rsp         (rsp0),
        .o_snoop_flags (snoop0)
    );

    tag_mem way1 (
        .i_clk         (i_clk),
        .i_nrst        (i_nrst),
        .i_req         (req1),
        .i_snoop_addr  (i_snoop_addr),
        .o_rsp         (rsp1),
        .o_snoop_flags (snoop1)
    );

    lru_table lru0 (
        .i_clk     (i_clk),
        .i_nrst    (i_nrst),
        .i_index   (i_req.addr[cache_pkg::LNBITS +: cache_pkg::IBITS]),
        .i_we      (|i_req.wstrb),
        .i_wway    (wr_way),
        .i_hit     (o_rsp.hit),
        .i_hit_way (o_hit_way),
        .o_victim  (victim)
    );

    // way 0 supplies the fields on a miss
    always_comb begin
        o_rsp     = rsp1.hit ? rsp1 : rsp0;
        o_rsp.hit = rsp0.hit | rsp1.hit;
        o_hit_way = rsp1.hit;
    end

    assign o_snoop_flags = snoop0 | snoop1;

endmodule

`default_nettype wire

// ==== tb/tb_cache_lines.sv ====
// cache line store testbench
`default_nettype none

module tb_cache_lines;

    localparam int NSTEPS     = 16;
    localparam int MAX_CYCLES = 500;
    localparam cache_pkg::wstrb_t PART_STRB = 16'h0f0f;   // partial update of the hit line

    typedef struct packed {
        cache_pkg::addr_t  addr;
        cache_pkg::wstrb_t wstrb;
        logic [3:0]        didx;        // entry of the data array
        cache_pkg::flags_t wflags;
        logic              refill;
        cache_pkg::way_t   wway;
        cache_pkg::addr_t  snoop;
        logic              chk;         // check the response
        logic              snp_chk;     // check the snoop flags
        logic              exp_hit;
        cache_pkg::way_t   exp_way;
        cache_pkg::flags_t exp_flags;
        cache_pkg::addr_t  exp_raddr;
        logic [3:0]        exp_didx;
        cache_pkg::flags_t exp_snoop;
    } step_t;

    // tag A lives in set 3 and tags B, C and D share set 5
    // tag E is never stored and every request uses byte offset 8
    // each row holds addr, wstrb, data, wflags, refill, wway and snoop
    // then chk, snp_chk and the expected hit, way, flags, raddr, data and snoop
    localparam step_t STEPS [NSTEPS] = '{
        '{32'hA000_0138, 16'h0000, 4'd0, 4'h0, 1'b0, 1'b0, 32'h0000_0000,     // A misses
          1'b1, 1'b0, 1'b0, 1'b0, 4'h0, 32'h0000_0000, 4'd0, 4'h0},
        '{32'hA000_0138, 16'hffff, 4'd0, 4'h1, 1'b1, 1'b0, 32'h0000_0000,     // refill A
          1'b0, 1'b0, 1'b0, 1'b0, 4'h0, 32'h0000_0000, 4'd0, 4'h0},
        '{32'hA000_0138, 16'h0000, 4'd0, 4'h0, 1'b0, 1'b0, 32'h0000_0000,
          1'b1, 1'b0, 1'b1, 1'b0, 4'h1, 32'hA000_0130, 4'd0, 4'h0},
        '{32'hB000_0258, 16'hffff, 4'd1, 4'h1, 1'b1, 1'b0, 32'h0000_0000,     // B into way 0
          1'b0, 1'b0, 1'b0, 1'b0, 4'h0, 32'h0000_0000, 4'd0, 4'h0},
        '{32'hC000_0358, 16'hffff, 4'd2, 4'h3, 1'b1, 1'b0, 32'h0000_0000,     // C into way 1
          1'b0, 1'b0, 1'b0, 1'b0, 4'h0, 32'h0000_0000, 4'd0, 4'h0},
        '{32'hC000_0358, 16'h0000, 4'd0, 4'h0, 1'b0, 1'b0, 32'hC000_0350,
          1'b1, 1'b1, 1'b1, 1'b1, 4'h3, 32'hC000_0350, 4'd2, 4'h3},
        '{32'hB000_0258, 16'h0000, 4'd0, 4'h0, 1'b0, 1'b0, 32'hE000_0550,
          1'b1, 1'b1, 1'b1, 1'b0, 4'h1, 32'hB000_0250, 4'd1, 4'h0},
        '{32'h0000_00f0, 16'h0000, 4'd0, 4'h0, 1'b0, 1'b0, 32'h0000_0000,     // let lru settle
          1'b1, 1'b0, 1'b0, 1'b0, 4'h0, 32'h0000_0000, 4'd0, 4'h0},
        '{32'hD000_0458, 16'hffff, 4'd3, 4'h1, 1'b1, 1'b0, 32'h0000_0000,     // D evicts C
          1'b0, 1'b0, 1'b0, 1'b0, 4'h0, 32'h0000_0000, 4'd0, 4'h0},
        '{32'hC000_0358, 16'h0000, 4'd0, 4'h0, 1'b0, 1'b0, 32'hA000_0130,
          1'b1, 1'b1, 1'b0, 1'b0, 4'h0, 32'h0000_0000, 4'd0, 4'h1},
        '{32'hD000_0458, 16'h0000, 4'd0, 4'h0, 1'b0, 1'b0, 32'h0000_0000,
          1'b1, 1'b0, 1'b1, 1'b1, 4'h1, 32'hD000_0450, 4'd3, 4'h0},
        '{32'hB000_0258, 16'h0000, 4'd0, 4'h0, 1'b0, 1'b0, 32'hD000_0450,
          1'b1, 1'b1, 1'b1, 1'b0, 4'h1, 32'hB000_0250, 4'd1, 4'h1},
        '{32'hB000_0258, PART_STRB, 4'd4, 4'h1, 1'b0, 1'b0, 32'h0000_0000,    // old line back
          1'b1, 1'b0, 1'b1, 1'b0, 4'h1, 32'hB000_0250, 4'd1, 4'h0},
        '{32'hB000_0258, 16'h0000, 4'd0, 4'h0, 1'b0, 1'b0, 32'h0000_0000,     // merged line
          1'b1, 1'b0, 1'b1, 1'b0, 4'h1, 32'hB000_0250, 4'd8, 4'h0},
        '{32'hB000_0258, 16'h0001, 4'd8, 4'h2, 1'b0, 1'b0, 32'h0000_0000,     // clear valid
          1'b1, 1'b0, 1'b1, 1'b0, 4'h1, 32'hB000_0250, 4'd8, 4'h0},
        '{32'hB000_0258, 16'h0000, 4'd0, 4'h0, 1'b0, 1'b0, 32'hB000_0250,
          1'b1, 1'b1, 1'b0, 1'b0, 4'h0, 32'h0000_0000, 4'd0, 4'h2}
    };

    logic                 i_clk = 1'b0;
    logic                 i_nrst;
    cache_pkg::line_req_t i_req;
    logic                 i_refill;
    cache_pkg::way_t      i_wway;
    cache_pkg::addr_t     i_snoop_addr;
    cache_pkg::line_rsp_t o_rsp;
    cache_pkg::way_t      o_hit_way;
    cache_pkg::flags_t    o_snoop_flags;

    cache_pkg::line_t data [9];     // entry 8 is the merge of entries 1 and 4
    integer           seed;

    cache_lines i_cache_lines (
        .i_clk         (i_clk),
        .i_nrst        (i_nrst),
        .i_req         (i_req),
        .i_refill      (i_refill),
        .i_wway        (i_wway),
        .i_snoop_addr  (i_snoop_addr),
        .o_rsp         (o_rsp),
        .o_hit_way     (o_hit_way),
        .o_snoop_flags (o_snoop_flags)
    );

    always #50 i_clk = ~i_clk;

    function automatic cache_pkg::line_t strobe_mask(input cache_pkg::wstrb_t strb);
        cache_pkg::line_t m;
        m = '0;
        for (int b = 0; b < cache_pkg::LINE_BYTES; b++) begin
            if (strb[b]) begin
                m[8*b +: 8] = 8'hff;
            end
        end
        return m;
    endfunction

    task automatic drive_request(input cache_pkg::addr_t addr, input cache_pkg::wstrb_t wstrb,
                                 input cache_pkg::line_t wdata, input cache_pkg::flags_t wflags,
                                 input logic refill, input cache_pkg::way_t wway,
                                 input cache_pkg::addr_t snoop);
        i_req.addr   <= addr;
        i_req.wstrb  <= wstrb;
        i_req.wdata  <= wdata;
        i_req.wflags <= wflags;
        i_refill     <= refill;
        i_wway       <= wway;
        i_snoop_addr <= snoop;
    endtask

    task automatic report_mismatch(input string name, input int k,
                                   input cache_pkg::line_t got, input cache_pkg::line_t exp);
        $display("ERR step %0d %s got %0h expected %0h", k, name, got, exp);
        $display("** FAIL **");
        $fatal(1, "value mismatch");
    endtask

    task automatic check_step(input step_t s, input int k);
        if (s.chk) begin
            assert (o_rsp.hit === s.exp_hit) else begin
                report_mismatch("o_rsp.hit", k, cache_pkg::line_t'(o_rsp.hit),
                                cache_pkg::line_t'(s.exp_hit));
            end
            if (s.exp_hit) begin    // fields only mean something on a hit
                assert (o_hit_way === s.exp_way) else begin
                    report_mismatch("o_hit_way", k, cache_pkg::line_t'(o_hit_way),
                                    cache_pkg::line_t'(s.exp_way));
                end
                assert (o_rsp.rflags === s.exp_flags) else begin
                    report_mismatch("o_rsp.rflags", k, cache_pkg::line_t'(o_rsp.rflags),
                                    cache_pkg::line_t'(s.exp_flags));
                end
                assert (o_rsp.raddr === s.exp_raddr) else begin
                    report_mismatch("o_rsp.raddr", k, cache_pkg::line_t'(o_rsp.raddr),
                                    cache_pkg::line_t'(s.exp_raddr));
                end
                assert (o_rsp.rdata === data[s.exp_didx]) else begin
                    report_mismatch("o_rsp.rdata", k, o_rsp.rdata, data[s.exp_didx]);
                end
            end
        end
        if (s.snp_chk) begin
            assert (o_snoop_flags === s.exp_snoop) else begin
                report_mismatch("o_snoop_flags", k, cache_pkg::line_t'(o_snoop_flags),
                                cache_pkg::line_t'(s.exp_snoop));
            end
        end
    endtask

    // watchdog bounds the whole run
    initial begin
        for (int cycles = 0; cycles < MAX_CYCLES; cycles++) begin
            @(posedge i_clk);
        end
        $display("timeout after %0d cycles, the run did not finish", MAX_CYCLES);
        $display("** FAIL **");
        $fatal(1, "timeout");
    end

    initial begin
        i_nrst       = 1'b0;
        i_req        = '0;
        i_refill     = 1'b0;
        i_wway       = 1'b0;
        i_snoop_addr = '0;
        seed         = 32'h59c0_9467;
        for (int i = 0; i < 8; i++) begin
            data[i] = {$random(seed), $random(seed), $random(seed), $random(seed)};
        end
        data[8] = (data[1] & ~strobe_mask(PART_STRB)) | (data[4] & strobe_mask(PART_STRB));

        repeat (5) @(posedge i_clk);
        i_nrst <= 1'b1;

        // every set of both ways gets tag 0 and flags 0 and the lru ends on way 0
        for (int idx = 0; idx < cache_pkg::SETS; idx++) begin
            for (int w = 0; w < 2; w++) begin
                @(posedge i_clk);
                drive_request(cache_pkg::addr_t'(idx) << cache_pkg::LNBITS, '1, '0, '0,
                              1'b0, cache_pkg::way_t'(w), '0);
            end
        end

        // step k is sampled one edge after it is driven and checked at the next negedge
        for (int k = 0; k <= NSTEPS; k++) begin
            @(posedge i_clk);
            if (k < NSTEPS) begin
                drive_request(STEPS[k].addr, STEPS[k].wstrb, data[STEPS[k].didx],
                              STEPS[k].wflags, STEPS[k].refill, STEPS[k].wway, STEPS[k].snoop);
            end else begin
                drive_request(32'h0000_00f0, '0, '0, '0, 1'b0, 1'b0, '0);
            end
            @(negedge i_clk);
            if (k > 0) begin
                check_step(STEPS[k-1], k - 1);
            end
        end

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
hdl/cache_pkg.sv
hdl/ram_tech.sv
hdl/ram_cache_bwe_tech.sv
hdl/tag_mem.sv
hdl/lru_table.sv
hdl/cache_lines.sv
tb/tb_cache_lines.sv

// ==== Makefile ====
TOP := tb_cache_lines

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): compile.f $(wildcard hdl/*.sv) $(wildcard tb/*.sv)
	verilator --binary --timing -j 0 --top-module $(TOP) -f compile.f

lint:
	verilator --lint-only -Wall --top-module cache_lines hdl/cache_pkg.sv hdl/ram_tech.sv \
		hdl/ram_cache_bwe_tech.sv hdl/tag_mem.sv hdl/lru_table.sv hdl/cache_lines.sv
	verilator --lint-only --timing --top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir
